// File: flist.f
verilog/fft_pkg.sv
verilog/fft_complex_mult.sv
verilog/fft_multi_butterfly.sv
verilog/fft_pease_stage.sv
verilog/fft_frame_loader.sv
verilog/fft_frame_unloader.sv
verilog/fft_top.sv
sim/fft_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the FFT testbench with Verilator, run it, then check the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module fft_tb -f flist.f -o fft_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/fft_sim > sim.log 2>&1
cat sim.log
grep -q "Done: no errors" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim/fft_tb.sv
//==========================================================================
// testbench for the streaming Pease FFT
//   clock, reset, frame stimulus, real-valued DFT reference model,
//   output monitor with immediate assertions, watchdog
//==========================================================================
`timescale 1ns/1ps

module fft_tb;

  localparam int width  = 16;
  localparam int frac   = 8;
  localparam int points = 8;
  localparam int stages = $clog2(points);
  // allowed distance from the rounded model value, in LSB
  localparam int tol    = 2 * stages;
  localparam real two_pi = 6.28318530717958647692;

  // impulse, constant, 6 random, 6 back to back, 6 gapped, partial, fresh
  localparam int n_frames     = 22;
  localparam int limit_cycles = n_frames * 3 * points + 200;
  // worst-case time to empty the chain once input stops
  localparam int drain_cycles = (stages + 3) * (points + points / 2 + 2);

  typedef int frame_t [points];

  logic             clk;
  logic             reset;
  logic             in_valid;
  logic [width-1:0] in_re;
  logic [width-1:0] in_im;
  logic             out_valid;
  logic [width-1:0] out_re;
  logic [width-1:0] out_im;
  logic             out_last;

  // expected bins in output order, frame after frame
  int exp_re [$];
  int exp_im [$];

  fft_top #(
    .width (width),
    .frac  (frac),
    .points(points)
  ) uut (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_re    (in_re),
    .in_im    (in_im),
    .out_valid(out_valid),
    .out_re   (out_re),
    .out_im   (out_im),
    .out_last (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  function automatic bit within_tolerance(input logic [width-1:0] got, input int want);
    int diff;
    diff = int'($signed(got)) - want;
    return (diff <= tol) && (diff >= -tol);
  endfunction

  // O(N^2) DFT in real arithmetic, results rounded to the nearest LSB
  task automatic queue_dft(input frame_t xr, input frame_t xi);
    real acc_re;
    real acc_im;
    real ang;
    for (int k = 0; k < points; k++) begin
      acc_re = 0.0;
      acc_im = 0.0;
      for (int n = 0; n < points; n++) begin
        ang    = -two_pi * real'((k * n) % points) / real'(points);
        acc_re = acc_re + real'(xr[n]) * $cos(ang) - real'(xi[n]) * $sin(ang);
        acc_im = acc_im + real'(xr[n]) * $sin(ang) + real'(xi[n]) * $cos(ang);
      end
      exp_re.push_back(int'(acc_re));
      exp_im.push_back(int'(acc_im));
    end
  endtask

  // parts kept inside +-(2^(width-1)/N) so no bin wraps
  task automatic random_frame(output frame_t xr, output frame_t xi);
    int bound;
    bound = (1 << (width - 1)) / points;
    for (int n = 0; n < points; n++) begin
      xr[n] = int'($urandom_range(2 * bound - 2, 0)) - (bound - 1);
      xi[n] = int'($urandom_range(2 * bound - 2, 0)) - (bound - 1);
    end
  endtask

  // strobes the first count samples, up to max_gap idle cycles after each
  // only a complete frame is expected at the output
  task automatic send_frame(input frame_t xr, input frame_t xi, input int max_gap,
                            input int count);
    int gap;
    if (count == points) begin
      queue_dft(xr, xi);
    end
    for (int n = 0; n < count; n++) begin
      @(posedge clk);
      in_valid <= 1'b1;
      in_re    <= width'(xr[n]);
      in_im    <= width'(xi[n]);
      gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
      repeat (gap) begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
    end
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // waits for every queued bin to come out, at most the drain time
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_re.size() != 0 && waited < drain_cycles) begin
      @(posedge clk);
      waited++;
    end
    idle_cycles(2 * points);
  endtask

  //========================================================================
  // stimulus
  //========================================================================
  initial begin : stimulus
    frame_t xr;
    frame_t xi;
    void'($urandom(32'h8ed95b9f));
    reset    = 1'b1;
    in_valid = 1'b0;
    in_re    = '0;
    in_im    = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // impulse of 1.0 at sample 0, flat spectrum
    for (int n = 0; n < points; n++) begin
      xr[n] = 0;
      xi[n] = 0;
    end
    xr[0] = 1 << frac;
    send_frame(xr, xi, 0, points);
    idle_cycles(1);

    // constant input, all energy in bin 0
    for (int n = 0; n < points; n++) begin
      xr[n] = 1000;
      xi[n] = -500;
    end
    send_frame(xr, xi, 0, points);
    idle_cycles(1);

    // random frames with short pauses between frames
    repeat (6) begin
      random_frame(xr, xi);
      send_frame(xr, xi, 0, points);
      idle_cycles(2);
    end

    // a strobe on every cycle across frame borders
    repeat (6) begin
      random_frame(xr, xi);
      send_frame(xr, xi, 0, points);
    end
    idle_cycles(1);

    // random gaps between strobes
    repeat (6) begin
      random_frame(xr, xi);
      send_frame(xr, xi, 2, points);
    end
    idle_cycles(1);
    wait_drained();

    // partial frame cut off by reset, nothing may come out
    random_frame(xr, xi);
    send_frame(xr, xi, 0, 5);
    @(posedge clk);
    in_valid <= 1'b0;
    reset    <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(4 * points);

    // fresh frame after the reset
    random_frame(xr, xi);
    send_frame(xr, xi, 0, points);
    idle_cycles(1);
    wait_drained();

    if (exp_re.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      fail_run("frames still pending at the end of the run");
    end
  end

  //========================================================================
  // output monitor, sampled on the falling edge
  //========================================================================
  initial begin : monitor
    int bin;
    int e_re;
    int e_im;
    bin = 0;
    forever begin
      @(negedge clk);
      if (reset) begin
        bin = 0;
      end else begin
        assert (!out_last || out_valid)
          else fail_run("out_last is high without out_valid");
        if (out_valid) begin
          assert (exp_re.size() > 0)
            else fail_run("output strobe while no frame is pending");
          e_re = exp_re.pop_front();
          e_im = exp_im.pop_front();
          assert (within_tolerance(out_re, e_re))
            else fail_run($sformatf("mismatch at %0t: bin %0d real %0d, expected %0d",
                                    $time, bin, $signed(out_re), e_re));
          assert (within_tolerance(out_im, e_im))
            else fail_run($sformatf("mismatch at %0t: bin %0d imag %0d, expected %0d",
                                    $time, bin, $signed(out_im), e_im));
          assert (out_last == (bin == points - 1))
            else fail_run($sformatf("mismatch at %0t: bin %0d out_last %0b",
                                    $time, bin, out_last));
          bin = (bin + 1) % points;
        end
      end
    end
  end

  // watchdog sized from the frame count
  initial begin : watchdog
    repeat (limit_cycles) @(posedge clk);
    fail_run("timeout: the output stream stopped before all frames came out");
  end

endmodule

// File: verilog/fft_complex_mult.sv
//==========================================================================
// combinational fixed-point complex multiplier
//   p = a * b, full-precision products, result truncated back to the
//   working format (width bits, frac fraction bits)
//==========================================================================
`timescale 1ns/1ps

module fft_complex_mult #(
  parameter int width = 16,
  parameter int frac  = 8
) (
  input  logic [width-1:0] ar,
  input  logic [width-1:0] ai,
  input  logic [width-1:0] br,
  input  logic [width-1:0] bi,
  output logic [width-1:0] pr,
  output logic [width-1:0] pi
);

  // four partial products, each exact
  logic signed [2*width-1:0] p_rr;
  logic signed [2*width-1:0] p_ii;
  logic signed [2*width-1:0] p_ri;
  logic signed [2*width-1:0] p_ir;

  // one extra bit so the sum or difference cannot overflow
  logic signed [2*width:0] sum_re;
  logic signed [2*width:0] sum_im;

  assign p_rr = $signed(ar) * $signed(br);
  assign p_ii = $signed(ai) * $signed(bi);
  assign p_ri = $signed(ar) * $signed(bi);
  assign p_ir = $signed(ai) * $signed(br);

  // (ar + j ai)(br + j bi) = (ar br - ai bi) + j (ar bi + ai br)
  assign sum_re = p_rr - p_ii;
  assign sum_im = p_ri + p_ir;

  // drop frac low bits, keep width bits above them
  assign pr = sum_re[frac +: width];
  assign pi = sum_im[frac +: width];

endmodule

// File: verilog/fft_frame_loader.sv
//==========================================================================
// frame loader
//   gathers strobed samples into two ping-pong banks, writing sample k
//   at the bit-reversed address, and offers each full bank downstream
//==========================================================================
`timescale 1ns/1ps

module fft_frame_loader #(
  parameter int width  = 16,
  parameter int points = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  logic [width-1:0] in_re,
  input  logic [width-1:0] in_im,
  output logic             frame_valid,
  input  logic             frame_ready,
  output logic [width-1:0] frame_re [points],
  output logic [width-1:0] frame_im [points]
);

  localparam int lg = $clog2(points);

  // sample storage, two banks
  logic [width-1:0] bank_re [2][points];
  logic [width-1:0] bank_im [2][points];

  fft_pkg::load_state_t bank_state [2];
  logic                 wr_bank;
  logic                 rd_bank;
  logic [lg-1:0]        cnt;

  function automatic logic [lg-1:0] bit_rev(input logic [lg-1:0] a);
    logic [lg-1:0] r;
    for (int b = 0; b < lg; b++) begin
      r[b] = a[lg-1-b];
    end
    return r;
  endfunction

  // sample write, payload only
  always_ff @(posedge clk) begin
    if (in_valid) begin
      bank_re[wr_bank][bit_rev(cnt)] <= in_re;
      bank_im[wr_bank][bit_rev(cnt)] <= in_im;
    end
  end

  //========================================================================
  // bank control
  //========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      bank_state[0] <= fft_pkg::fill;
      bank_state[1] <= fft_pkg::fill;
      wr_bank       <= 1'b0;
      rd_bank       <= 1'b0;
      cnt           <= '0;
    end else begin
      // bank handed to stage 0 is free again
      if (frame_valid && frame_ready) begin
        bank_state[rd_bank] <= fft_pkg::fill;
        rd_bank             <= ~rd_bank;
      end
      if (in_valid) begin
        cnt <= cnt + 1'b1;
        // last sample closes the bank, switch to the other one
        if (cnt == lg'(points - 1)) begin
          bank_state[wr_bank] <= fft_pkg::hold;
          wr_bank             <= ~wr_bank;
        end
      end
    end
  end

  assign frame_valid = (bank_state[rd_bank] == fft_pkg::hold);

  always_comb begin
    for (int i = 0; i < points; i++) begin
      frame_re[i] = bank_re[rd_bank][i];
      frame_im[i] = bank_im[rd_bank][i];
    end
  end

endmodule

// File: verilog/fft_frame_unloader.sv
//==========================================================================
// frame unloader
//   takes a finished frame, then streams bins 0 .. n-1 as one strobe per
//   cycle and flags the last bin; accepts the next frame on that last
//   cycle so frames can follow without a gap
//==========================================================================
`timescale 1ns/1ps

module fft_frame_unloader #(
  parameter int width  = 16,
  parameter int points = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_valid,
  output logic             frame_ready,
  input  logic [width-1:0] frame_re [points],
  input  logic [width-1:0] frame_im [points],
  output logic             out_valid,
  output logic [width-1:0] out_re,
  output logic [width-1:0] out_im,
  output logic             out_last
);

  localparam int lg = $clog2(points);

  logic [width-1:0] buf_re [points];
  logic [width-1:0] buf_im [points];

  fft_pkg::unload_state_t state;
  logic [lg-1:0]          idx;
  logic                   at_last;

  assign at_last     = (idx == lg'(points - 1));
  assign frame_ready = (state == fft_pkg::empty) || (state == fft_pkg::drain && at_last);

  // frame copy
  always_ff @(posedge clk) begin
    if (frame_valid && frame_ready) begin
      buf_re <= frame_re;
      buf_im <= frame_im;
    end
  end

  //========================================================================
  // drain control
  //========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_pkg::empty;
      idx   <= '0;
    end else if (frame_valid && frame_ready) begin
      // new frame, start again at bin 0
      state <= fft_pkg::drain;
      idx   <= '0;
    end else if (state == fft_pkg::drain) begin
      if (at_last) begin
        state <= fft_pkg::empty;
      end
      idx <= idx + 1'b1;
    end
  end

  assign out_valid = (state == fft_pkg::drain);
  assign out_last  = (state == fft_pkg::drain) && at_last;
  assign out_re    = buf_re[idx];
  assign out_im    = buf_im[idx];

endmodule

// File: verilog/fft_multi_butterfly.sv
//==========================================================================
// buffered multi-butterfly
//   takes a whole frame of n/2 butterfly inputs on a valid/ready handshake,
//   computes c = a + b*w and d = a - b*w one butterfly per cycle on a
//   single shared complex multiplier, then offers the results downstream
//==========================================================================
`timescale 1ns/1ps

module fft_multi_butterfly #(
  parameter int width  = 16,
  parameter int frac   = 8,
  parameter int points = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             recv_valid,
  output logic             recv_ready,
  output logic             send_valid,
  input  logic             send_ready,
  input  logic [width-1:0] ar [points/2],
  input  logic [width-1:0] ai [points/2],
  input  logic [width-1:0] br [points/2],
  input  logic [width-1:0] bi [points/2],
  input  logic [width-1:0] wr [points/2],
  input  logic [width-1:0] wi [points/2],
  output logic [width-1:0] cr [points/2],
  output logic [width-1:0] ci [points/2],
  output logic [width-1:0] dr [points/2],
  output logic [width-1:0] di [points/2]
);

  localparam int bflys = points / 2;
  localparam int idx_w = $clog2(bflys);
  localparam logic [idx_w-1:0] last_idx = idx_w'(bflys - 1);

  // captured frame
  logic [width-1:0] s_ar [bflys];
  logic [width-1:0] s_ai [bflys];
  logic [width-1:0] s_br [bflys];
  logic [width-1:0] s_bi [bflys];
  logic [width-1:0] s_wr [bflys];
  logic [width-1:0] s_wi [bflys];

  fft_pkg::bfly_state_t state;
  logic [idx_w-1:0]     idx;

  // b*w of the butterfly being worked on
  logic [width-1:0] m_re;
  logic [width-1:0] m_im;

  fft_complex_mult #(
    .width(width),
    .frac (frac)
  ) u_mult (
    .ar(s_br[idx]),
    .ai(s_bi[idx]),
    .br(s_wr[idx]),
    .bi(s_wi[idx]),
    .pr(m_re),
    .pi(m_im)
  );

  // handshake follows the FSM directly
  assign recv_ready = (state == fft_pkg::idle);
  assign send_valid = (state == fft_pkg::done);

  //========================================================================
  // control
  //========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fft_pkg::idle;
      idx   <= '0;
    end else begin
      case (state)
        fft_pkg::idle: begin
          if (recv_valid) begin
            state <= fft_pkg::comp;
            idx   <= '0;
          end
        end
        fft_pkg::comp: begin
          // one butterfly per cycle, last one moves us to done
          if (idx == last_idx) begin
            state <= fft_pkg::done;
            idx   <= '0;
          end else begin
            idx <= idx + 1'b1;
          end
        end
        fft_pkg::done: begin
          if (send_ready) begin
            state <= fft_pkg::idle;
          end
        end
        default: state <= fft_pkg::idle;
      endcase
    end
  end

  //========================================================================
  // datapath
  //========================================================================
  always_ff @(posedge clk) begin
    if (recv_valid && recv_ready) begin
      for (int i = 0; i < bflys; i++) begin
        s_ar[i] <= ar[i];
        s_ai[i] <= ai[i];
        s_br[i] <= br[i];
        s_bi[i] <= bi[i];
        s_wr[i] <= wr[i];
        s_wi[i] <= wi[i];
      end
    end
    // wrap-around add and subtract, no saturation
    if (state == fft_pkg::comp) begin
      cr[idx] <= s_ar[idx] + m_re;
      ci[idx] <= s_ai[idx] + m_im;
      dr[idx] <= s_ar[idx] - m_re;
      di[idx] <= s_ai[idx] - m_im;
    end
  end

endmodule

// File: verilog/fft_pease_stage.sv
//==========================================================================
// one Pease FFT stage
//   pairs adjacent elements into butterflies, selects the constant
//   twiddle of each butterfly for this stage, and routes the results
//   through the perfect shuffle
//==========================================================================
`timescale 1ns/1ps

module fft_pease_stage #(
  parameter int width  = 16,
  parameter int frac   = 8,
  parameter int points = 8,
  parameter int stage  = 0
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  output logic             out_valid,
  input  logic             out_ready,
  input  logic [width-1:0] in_re  [points],
  input  logic [width-1:0] in_im  [points],
  output logic [width-1:0] out_re [points],
  output logic [width-1:0] out_im [points]
);

  localparam int stages = $clog2(points);
  localparam int half   = points / 2;
  // low exponent bits cleared by this stage
  localparam int shift  = stages - 1 - stage;

  logic [width-1:0] a_re [half];
  logic [width-1:0] a_im [half];
  logic [width-1:0] b_re [half];
  logic [width-1:0] b_im [half];
  logic [width-1:0] w_re [half];
  logic [width-1:0] w_im [half];
  logic [width-1:0] c_re [half];
  logic [width-1:0] c_im [half];
  logic [width-1:0] d_re [half];
  logic [width-1:0] d_im [half];

  for (genvar i = 0; i < half; i++) begin : g_bfly
    localparam int k = (i >> shift) << shift;
    localparam logic [width-1:0] tw_re = width'(fft_pkg::twiddle_re(k, points, frac));
    localparam logic [width-1:0] tw_im = width'(fft_pkg::twiddle_im(k, points, frac));

    // butterfly i reads the adjacent pair 2i, 2i+1
    assign a_re[i] = in_re[2*i];
    assign a_im[i] = in_im[2*i];
    assign b_re[i] = in_re[2*i+1];
    assign b_im[i] = in_im[2*i+1];
    assign w_re[i] = tw_re;
    assign w_im[i] = tw_im;

    // perfect shuffle on the way out
    assign out_re[i]      = c_re[i];
    assign out_im[i]      = c_im[i];
    assign out_re[i+half] = d_re[i];
    assign out_im[i+half] = d_im[i];
  end

  fft_multi_butterfly #(
    .width (width),
    .frac  (frac),
    .points(points)
  ) u_bfly (
    .clk       (clk),
    .reset     (reset),
    .recv_valid(in_valid),
    .recv_ready(in_ready),
    .send_valid(out_valid),
    .send_ready(out_ready),
    .ar(a_re), .ai(a_im), .br(b_re), .bi(b_im), .wr(w_re), .wi(w_im),
    .cr(c_re), .ci(c_im), .dr(d_re), .di(d_im)
  );

endmodule

// File: verilog/fft_pkg.sv
//==========================================================================
// shared definitions for the streaming Pease FFT
//   bfly_state_t   : multi-butterfly FSM states
//   load_state_t   : per-bank state of the frame loader
//   unload_state_t : frame unloader FSM states
//   twiddle_re/im  : constant functions for the twiddle tables
//==========================================================================
package fft_pkg;

  typedef enum logic [1:0] {idle, comp, done} bfly_state_t;

  typedef enum logic {fill, hold} load_state_t;

  typedef enum logic {empty, drain} unload_state_t;

  localparam real math_pi = 3.14159265358979323846;

  // real part of e^(-2*pi*i*k/n) in fixed point with d fraction bits
  // truncated toward zero, callers narrow to their own width
  function automatic longint twiddle_re(input int k, input int n, input int d);
    real angle;
    angle = -2.0 * math_pi * real'(k) / real'(n);
    return longint'($rtoi($cos(angle) * (2.0 ** d)));
  endfunction

  // imaginary part, same scaling
  function automatic longint twiddle_im(input int k, input int n, input int d);
    real angle;
    angle = -2.0 * math_pi * real'(k) / real'(n);
    return longint'($rtoi($sin(angle) * (2.0 ** d)));
  endfunction

endpackage

// File: verilog/fft_top.sv
//==========================================================================
// streaming Pease FFT, top level
//   loader -> log2(points) Pease stages -> unloader
//==========================================================================
`timescale 1ns/1ps

module fft_top #(
  parameter int width  = 16,
  parameter int frac   = 8,
  parameter int points = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  logic [width-1:0] in_re,
  input  logic [width-1:0] in_im,
  output logic             out_valid,
  output logic [width-1:0] out_re,
  output logic [width-1:0] out_im,
  output logic             out_last
);

  localparam int stages = $clog2(points);

  // link s feeds stage s, link stages feeds the unloader
  logic             frame_valid [stages+1];
  logic             frame_ready [stages+1];
  logic [width-1:0] frame_re    [stages+1][points];
  logic [width-1:0] frame_im    [stages+1][points];

  fft_frame_loader #(
    .width (width),
    .points(points)
  ) u_loader (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_re      (in_re),
    .in_im      (in_im),
    .frame_valid(frame_valid[0]),
    .frame_ready(frame_ready[0]),
    .frame_re   (frame_re[0]),
    .frame_im   (frame_im[0])
  );

  for (genvar s = 0; s < stages; s++) begin : g_stage
    fft_pease_stage #(
      .width (width),
      .frac  (frac),
      .points(points),
      .stage (s)
    ) u_stage (
      .clk      (clk),
      .reset    (reset),
      .in_valid (frame_valid[s]),
      .in_ready (frame_ready[s]),
      .out_valid(frame_valid[s+1]),
      .out_ready(frame_ready[s+1]),
      .in_re    (frame_re[s]),
      .in_im    (frame_im[s]),
      .out_re   (frame_re[s+1]),
      .out_im   (frame_im[s+1])
    );
  end

  fft_frame_unloader #(
    .width (width),
    .points(points)
  ) u_unloader (
    .clk        (clk),
    .reset      (reset),
    .frame_valid(frame_valid[stages]),
    .frame_ready(frame_ready[stages]),
    .frame_re   (frame_re[stages]),
    .frame_im   (frame_im[stages]),
    .out_valid  (out_valid),
    .out_re     (out_re),
    .out_im     (out_im),
    .out_last   (out_last)
  );

endmodule
